//--- hdl/video_filter_pkg.sv
`default_nettype none

package video_filter_pkg;

    // ****************************************
    // Widths with a meaning.
    // ****************************************

    typedef logic [23:0] pixel_t;
    typedef logic [7:0]  channel_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [16:0] wb_addr_t;
    typedef logic [3:0]  wb_sel_t;

    typedef enum logic [1:0] {
        mode_pass,
        mode_invert,
        mode_gray,
        mode_binarize
    } filter_mode_t;

    // One stream beat, tuser as sof and tlast as eol.
    typedef struct packed {
        pixel_t pixel;
        logic   sof;
        logic   eol;
    } pixel_beat_t;

    typedef struct packed {
        logic         enable;
        filter_mode_t mode;
        channel_t     threshold;
    } filter_cfg_t;

    // ****************************************
    // Register map, word addresses.
    // ****************************************

    localparam wb_addr_t ADR_CORE_ID      = 17'h00;
    localparam wb_addr_t ADR_CORE_VERSION = 17'h01;
    localparam wb_addr_t ADR_ENABLE       = 17'h08;
    localparam wb_addr_t ADR_MODE         = 17'h09;
    localparam wb_addr_t ADR_THRESHOLD    = 17'h0A;
    localparam wb_addr_t ADR_FRAME_COUNT  = 17'h10;

    localparam wb_data_t CORE_ID      = 32'h5646_0101;
    localparam wb_data_t CORE_VERSION = 32'h0001_0000;

endpackage

`default_nettype wire

//--- hdl/video_filter_regs.sv
`timescale 1ns/1ps
`default_nettype none

module video_filter_regs
    import video_filter_pkg::*;
    #(
        parameter logic INIT_ENABLE       = 1'b0,
        parameter int   FRAME_COUNT_WIDTH = 16
    )
    (
        input  wire                          s_wb_clk_i,
        input  wire                          s_wb_rst_i,

        input  wire wb_addr_t                s_wb_adr_i,
        input  wire wb_data_t                s_wb_dat_i,
        output wb_data_t                     s_wb_dat_o,
        input  wire                          s_wb_we_i,
        input  wire wb_sel_t                 s_wb_sel_i,
        input  wire                          s_wb_stb_i,
        output logic                         s_wb_ack_o,

        input  wire [FRAME_COUNT_WIDTH-1:0]  frame_count_i,
        output filter_cfg_t                  cfg_o
    );

    localparam channel_t INIT_THRESHOLD = 8'h80;

    logic         reg_enable;
    filter_mode_t reg_mode;
    channel_t     reg_threshold;

    logic         wr_en;

    // Merge new data into the old value byte by byte.
    function automatic wb_data_t write_mask(
        input wb_data_t org,
        input wb_data_t wdat,
        input wb_sel_t  msk
    );
        wb_data_t res;
        res = org;
        for (int i = 0; i < 4; i++) begin
            if (msk[i]) begin
                res[i*8 +: 8] = wdat[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = s_wb_stb_i && s_wb_we_i;

    // ****************************************
    // Register writes.
    // ****************************************

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            reg_enable    <= INIT_ENABLE;
            reg_mode      <= mode_pass;
            reg_threshold <= INIT_THRESHOLD;
        end else if (wr_en) begin
            case (s_wb_adr_i)
                ADR_ENABLE: begin
                    reg_enable <= 1'(write_mask(wb_data_t'(reg_enable), s_wb_dat_i,
                                                s_wb_sel_i));
                end
                ADR_MODE: begin
                    reg_mode <= filter_mode_t'(2'(write_mask(wb_data_t'(reg_mode),
                                                             s_wb_dat_i, s_wb_sel_i)));
                end
                ADR_THRESHOLD: begin
                    reg_threshold <= 8'(write_mask(wb_data_t'(reg_threshold), s_wb_dat_i,
                                                   s_wb_sel_i));
                end
                default: begin
                end
            endcase
        end
    end

    // ****************************************
    // Read mux.
    // ****************************************

    always_comb begin
        case (s_wb_adr_i)
            ADR_CORE_ID:      s_wb_dat_o = CORE_ID;
            ADR_CORE_VERSION: s_wb_dat_o = CORE_VERSION;
            ADR_ENABLE:       s_wb_dat_o = wb_data_t'(reg_enable);
            ADR_MODE:         s_wb_dat_o = wb_data_t'(reg_mode);
            ADR_THRESHOLD:    s_wb_dat_o = wb_data_t'(reg_threshold);
            ADR_FRAME_COUNT:  s_wb_dat_o = wb_data_t'(frame_count_i);
            default:          s_wb_dat_o = '0;
        endcase
    end

    assign s_wb_ack_o = s_wb_stb_i;

    assign cfg_o.enable    = reg_enable;
    assign cfg_o.mode      = reg_mode;
    assign cfg_o.threshold = reg_threshold;

endmodule

`default_nettype wire

//--- hdl/video_filter_pixel_op.sv
`timescale 1ns/1ps
`default_nettype none

module video_filter_pixel_op
    import video_filter_pkg::*;
    (
        input  wire               s_wb_clk_i,
        input  wire               s_wb_rst_i,

        input  wire filter_cfg_t  cfg_i,

        input  wire pixel_t       s_axi4s_tdata_i,
        input  wire               s_axi4s_tuser_i,
        input  wire               s_axi4s_tlast_i,
        input  wire               s_axi4s_tvalid_i,
        output logic              s_axi4s_tready_o,

        output pixel_beat_t       beat_o,
        output logic              beat_valid_o,
        input  wire               beat_ready_i
    );

    // Luma weights, sum to 256.
    localparam logic [15:0] LUMA_W_R = 16'd77;
    localparam logic [15:0] LUMA_W_G = 16'd150;
    localparam logic [15:0] LUMA_W_B = 16'd29;

    filter_cfg_t cfg_q;
    filter_cfg_t cfg_eff;
    logic        in_accept;

    logic        s1_valid;
    logic        s1_ready;
    pixel_beat_t s1_beat;
    pixel_t      s1_inv;
    filter_cfg_t s1_cfg;
    logic [15:0] s1_prod_r;
    logic [15:0] s1_prod_g;
    logic [15:0] s1_prod_b;

    logic        s2_valid;
    logic        s2_ready;
    pixel_beat_t s2_beat;

    logic [15:0] luma_sum;
    channel_t    luma;
    pixel_t      op_pixel;

    // Bubbles collapse, each stage moves when the next one is free.
    assign s2_ready         = !s2_valid || beat_ready_i;
    assign s1_ready         = !s1_valid || s2_ready;
    assign s_axi4s_tready_o = s1_ready;
    assign in_accept        = s_axi4s_tvalid_i && s1_ready;

    // The sof beat already uses the new settings.
    assign cfg_eff = s_axi4s_tuser_i ? cfg_i : cfg_q;

    // ****************************************
    // Stage 1.
    // ****************************************

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            cfg_q    <= '{enable: 1'b0, mode: mode_pass, threshold: 8'h80};
            s1_valid <= 1'b0;
        end else begin
            if (in_accept && s_axi4s_tuser_i) begin
                cfg_q <= cfg_i;
            end
            if (s1_ready) begin
                s1_valid <= s_axi4s_tvalid_i;
            end
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (in_accept) begin
            s1_beat.pixel <= s_axi4s_tdata_i;
            s1_beat.sof   <= s_axi4s_tuser_i;
            s1_beat.eol   <= s_axi4s_tlast_i;
            s1_inv        <= ~s_axi4s_tdata_i;
            s1_cfg        <= cfg_eff;
            s1_prod_r     <= 16'(s_axi4s_tdata_i[23:16]) * LUMA_W_R;
            s1_prod_g     <= 16'(s_axi4s_tdata_i[15:8]) * LUMA_W_G;
            s1_prod_b     <= 16'(s_axi4s_tdata_i[7:0]) * LUMA_W_B;
        end
    end

    // ****************************************
    // Stage 2.
    // ****************************************

    assign luma_sum = s1_prod_r + s1_prod_g + s1_prod_b;
    assign luma     = luma_sum[15:8];

    always_comb begin
        op_pixel = s1_beat.pixel;
        if (s1_cfg.enable) begin
            case (s1_cfg.mode)
                mode_invert:   op_pixel = s1_inv;
                mode_gray:     op_pixel = {luma, luma, luma};
                mode_binarize: op_pixel = (luma >= s1_cfg.threshold) ? '1 : '0;
                default:       op_pixel = s1_beat.pixel;
            endcase
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            s2_valid <= 1'b0;
        end else if (s2_ready) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (s2_ready && s1_valid) begin
            s2_beat.pixel <= op_pixel;
            s2_beat.sof   <= s1_beat.sof;
            s2_beat.eol   <= s1_beat.eol;
        end
    end

    assign beat_o       = s2_beat;
    assign beat_valid_o = s2_valid;

endmodule

`default_nettype wire

//--- hdl/video_filter_out_buf.sv
`timescale 1ns/1ps
`default_nettype none

module video_filter_out_buf
    import video_filter_pkg::*;
    #(
        parameter int FRAME_COUNT_WIDTH = 16
    )
    (
        input  wire                          s_wb_clk_i,
        input  wire                          s_wb_rst_i,

        input  wire pixel_beat_t             beat_i,
        input  wire                          beat_valid_i,
        output logic                         beat_ready_o,

        output pixel_t                       m_axi4s_tdata_o,
        output logic                         m_axi4s_tuser_o,
        output logic                         m_axi4s_tlast_o,
        output logic                         m_axi4s_tvalid_o,
        input  wire                          m_axi4s_tready_i,

        output logic [FRAME_COUNT_WIDTH-1:0] frame_count_o
    );

    pixel_beat_t out_q;
    logic        out_valid;
    logic        out_ready;
    pixel_beat_t skid_q;
    logic        skid_valid;
    logic        in_hs;
    logic        out_hs;

    logic [FRAME_COUNT_WIDTH-1:0] frame_count_q;

    // Upstream ready comes straight from a flop.
    assign beat_ready_o = !skid_valid;
    assign in_hs        = beat_valid_i && beat_ready_o;
    assign out_ready    = !out_valid || m_axi4s_tready_i;
    assign out_hs       = out_valid && m_axi4s_tready_i;

    // ****************************************
    // Output and skid entries.
    // ****************************************

    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid  <= skid_valid || beat_valid_i;
            skid_valid <= 1'b0;
        end else if (in_hs) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge s_wb_clk_i) begin
        if (out_ready) begin
            out_q <= skid_valid ? skid_q : beat_i;
        end
        if (!out_ready && in_hs) begin
            skid_q <= beat_i;
        end
    end

    // Counts sof beats handed downstream.
    always_ff @(posedge s_wb_clk_i) begin
        if (s_wb_rst_i) begin
            frame_count_q <= '0;
        end else if (out_hs && out_q.sof) begin
            frame_count_q <= frame_count_q + FRAME_COUNT_WIDTH'(1);
        end
    end

    assign m_axi4s_tdata_o  = out_q.pixel;
    assign m_axi4s_tuser_o  = out_q.sof;
    assign m_axi4s_tlast_o  = out_q.eol;
    assign m_axi4s_tvalid_o = out_valid;
    assign frame_count_o    = frame_count_q;

endmodule

`default_nettype wire

//--- hdl/video_filter.sv
`timescale 1ns/1ps
`default_nettype none

module video_filter
    import video_filter_pkg::*;
    #(
        parameter logic INIT_ENABLE       = 1'b0,
        parameter int   FRAME_COUNT_WIDTH = 16
    )
    (
        input  wire             s_wb_clk_i,
        input  wire             s_wb_rst_i,

        input  wire wb_addr_t   s_wb_adr_i,
        input  wire wb_data_t   s_wb_dat_i,
        output wb_data_t        s_wb_dat_o,
        input  wire             s_wb_we_i,
        input  wire wb_sel_t    s_wb_sel_i,
        input  wire             s_wb_stb_i,
        output logic            s_wb_ack_o,

        input  wire pixel_t     s_axi4s_tdata_i,
        input  wire             s_axi4s_tuser_i,
        input  wire             s_axi4s_tlast_i,
        input  wire             s_axi4s_tvalid_i,
        output logic            s_axi4s_tready_o,

        output pixel_t          m_axi4s_tdata_o,
        output logic            m_axi4s_tuser_o,
        output logic            m_axi4s_tlast_o,
        output logic            m_axi4s_tvalid_o,
        input  wire             m_axi4s_tready_i
    );

    filter_cfg_t                  cfg;
    pixel_beat_t                  beat;
    logic                         beat_valid;
    logic                         beat_ready;
    logic [FRAME_COUNT_WIDTH-1:0] frame_count;

    // ****************************************
    // Decode, execute, result.
    // ****************************************

    video_filter_regs #(
        .INIT_ENABLE       (INIT_ENABLE),
        .FRAME_COUNT_WIDTH (FRAME_COUNT_WIDTH)
    ) u_regs (
        .s_wb_clk_i    (s_wb_clk_i),
        .s_wb_rst_i    (s_wb_rst_i),
        .s_wb_adr_i    (s_wb_adr_i),
        .s_wb_dat_i    (s_wb_dat_i),
        .s_wb_dat_o    (s_wb_dat_o),
        .s_wb_we_i     (s_wb_we_i),
        .s_wb_sel_i    (s_wb_sel_i),
        .s_wb_stb_i    (s_wb_stb_i),
        .s_wb_ack_o    (s_wb_ack_o),
        .frame_count_i (frame_count),
        .cfg_o         (cfg)
    );

    video_filter_pixel_op u_pixel_op (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .cfg_i            (cfg),
        .s_axi4s_tdata_i  (s_axi4s_tdata_i),
        .s_axi4s_tuser_i  (s_axi4s_tuser_i),
        .s_axi4s_tlast_i  (s_axi4s_tlast_i),
        .s_axi4s_tvalid_i (s_axi4s_tvalid_i),
        .s_axi4s_tready_o (s_axi4s_tready_o),
        .beat_o           (beat),
        .beat_valid_o     (beat_valid),
        .beat_ready_i     (beat_ready)
    );

    video_filter_out_buf #(
        .FRAME_COUNT_WIDTH (FRAME_COUNT_WIDTH)
    ) u_out_buf (
        .s_wb_clk_i       (s_wb_clk_i),
        .s_wb_rst_i       (s_wb_rst_i),
        .beat_i           (beat),
        .beat_valid_i     (beat_valid),
        .beat_ready_o     (beat_ready),
        .m_axi4s_tdata_o  (m_axi4s_tdata_o),
        .m_axi4s_tuser_o  (m_axi4s_tuser_o),
        .m_axi4s_tlast_o  (m_axi4s_tlast_o),
        .m_axi4s_tvalid_o (m_axi4s_tvalid_o),
        .m_axi4s_tready_i (m_axi4s_tready_i),
        .frame_count_o    (frame_count)
    );

endmodule

`default_nettype wire

//--- sim/video_filter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module video_filter_assertions
    import video_filter_pkg::*;
    (
        input wire         clk_i,
        input wire         rst_i,
        input wire         stb_i,
        input wire         ack_i,
        input wire         in_valid_i,
        input wire         in_ready_i,
        input wire pixel_t out_data_i,
        input wire         out_user_i,
        input wire         out_last_i,
        input wire         out_valid_i,
        input wire         out_ready_i
    );

    int unsigned fail_count = 0;
    int unsigned in_count;
    int unsigned out_count;

    // Beats seen on each side of the DUT.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_count  <= 0;
            out_count <= 0;
        end else begin
            if (in_valid_i && in_ready_i) begin
                in_count <= in_count + 1;
            end
            if (out_valid_i && out_ready_i) begin
                out_count <= out_count + 1;
            end
        end
    end

    // ****************************************
    // Bus and stream protocol.
    // ****************************************

    ack_follows_stb: assert property (@(posedge clk_i) ack_i == stb_i)
        else begin
            fail_count++;
            $error("Wishbone ack differs from stb.");
        end

    out_held_on_stall: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i)
            && $stable(out_user_i) && $stable(out_last_i))
        else begin
            fail_count++;
            $error("Output beat changed or dropped while stalled.");
        end

    idle_after_reset: assert property (@(posedge clk_i)
        rst_i |=> !out_valid_i && in_ready_i)
        else begin
            fail_count++;
            $error("Stream not idle after reset.");
        end

    no_extra_output: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_i && out_ready_i |-> out_count < in_count)
        else begin
            fail_count++;
            $error("More beats left the DUT than entered it.");
        end

endmodule

`default_nettype wire

//--- sim/tb_video_filter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_filter
    import video_filter_pkg::*;
    ();

    localparam int          CLK_PERIOD      = 100;
    localparam int          FRAME_BEATS     = 16;
    localparam int          LINE_BEATS      = 4;
    localparam int          N_FRAMES        = 11;
    localparam int          STALL_FACTOR    = 8;
    localparam int          WATCHDOG_CYCLES = N_FRAMES * FRAME_BEATS * STALL_FACTOR + 400;
    localparam logic [15:0] LFSR_SEED       = 16'd43674;
    localparam filter_cfg_t RESET_CFG       = '{enable: 1'b0, mode: mode_pass, threshold: 8'h80};

    logic        clk;
    logic        rst;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_we;
    wb_sel_t     wb_sel;
    logic        wb_stb;
    logic        wb_ack;
    pixel_t      s_tdata;
    logic        s_tuser;
    logic        s_tlast;
    logic        s_tvalid;
    logic        s_tready;
    pixel_t      m_tdata;
    logic        m_tuser;
    logic        m_tlast;
    logic        m_tvalid;
    logic        m_tready;

    filter_cfg_t shadow_cfg;
    pixel_beat_t exp_q[$];
    pixel_beat_t exp_out;
    logic [15:0] stim_lfsr;
    logic [15:0] ready_lfsr;
    logic [23:0] ready_bits;
    logic        ready_gaps;
    int          frames_sent;

    video_filter #(
        .INIT_ENABLE       (1'b0),
        .FRAME_COUNT_WIDTH (16)
    ) DUT (
        .s_wb_clk_i       (clk),
        .s_wb_rst_i       (rst),
        .s_wb_adr_i       (wb_adr),
        .s_wb_dat_i       (wb_dat_w),
        .s_wb_dat_o       (wb_dat_r),
        .s_wb_we_i        (wb_we),
        .s_wb_sel_i       (wb_sel),
        .s_wb_stb_i       (wb_stb),
        .s_wb_ack_o       (wb_ack),
        .s_axi4s_tdata_i  (s_tdata),
        .s_axi4s_tuser_i  (s_tuser),
        .s_axi4s_tlast_i  (s_tlast),
        .s_axi4s_tvalid_i (s_tvalid),
        .s_axi4s_tready_o (s_tready),
        .m_axi4s_tdata_o  (m_tdata),
        .m_axi4s_tuser_o  (m_tuser),
        .m_axi4s_tlast_o  (m_tlast),
        .m_axi4s_tvalid_o (m_tvalid),
        .m_axi4s_tready_i (m_tready)
    );

    bind video_filter video_filter_assertions u_assertions (
        .clk_i       (s_wb_clk_i),
        .rst_i       (s_wb_rst_i),
        .stb_i       (s_wb_stb_i),
        .ack_i       (s_wb_ack_o),
        .in_valid_i  (s_axi4s_tvalid_i),
        .in_ready_i  (s_axi4s_tready_o),
        .out_data_i  (m_axi4s_tdata_o),
        .out_user_i  (m_axi4s_tuser_o),
        .out_last_i  (m_axi4s_tlast_o),
        .out_valid_i (m_axi4s_tvalid_o),
        .out_ready_i (m_axi4s_tready_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ****************************************
    // Helpers.
    // ****************************************

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(inout logic [15:0] state, input int n, output logic [23:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits  = {bits[22:0], state[0]};
        end
    endtask

    // Point operations as the filter spec defines them.
    function automatic pixel_t expected_pixel(input pixel_t px, input filter_cfg_t cfg);
        int       sum;
        channel_t y;
        sum = 77 * int'(px[23:16]) + 150 * int'(px[15:8]) + 29 * int'(px[7:0]);
        y   = channel_t'(sum / 256);
        if (!cfg.enable) begin
            return px;
        end
        case (cfg.mode)
            mode_invert:   return ~px;
            mode_gray:     return {y, y, y};
            mode_binarize: return (y >= cfg.threshold) ? 24'hFF_FFFF : 24'h00_0000;
            default:       return px;
        endcase
    endfunction

    task automatic fail_stop();
        $display("Something failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_field(input string name, input logic [23:0] exp, input logic [23:0] got);
        if (exp !== got) begin
            $display("ERR %s expected %h got %h", name, exp, got);
            fail_stop();
        end
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        @(negedge clk);
        wb_adr   = adr;
        wb_dat_w = dat;
        wb_sel   = sel;
        wb_we    = 1'b1;
        wb_stb   = 1'b1;
        @(negedge clk);
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        // All settings sit in byte 0.
        if (sel[0]) begin
            case (adr)
                ADR_ENABLE:    shadow_cfg.enable    = dat[0];
                ADR_MODE:      shadow_cfg.mode      = filter_mode_t'(dat[1:0]);
                ADR_THRESHOLD: shadow_cfg.threshold = dat[7:0];
                default: begin
                end
            endcase
        end
    endtask

    task automatic wb_check(input wb_addr_t adr, input wb_data_t exp);
        @(negedge clk);
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_stb = 1'b1;
        @(posedge clk);
        if (wb_dat_r !== exp) begin
            $display("ERR s_wb_dat_o at %h expected %h got %h", adr, exp, wb_dat_r);
            fail_stop();
        end
        @(negedge clk);
        wb_stb = 1'b0;
    endtask

    task automatic check_cfg_regs();
        wb_check(ADR_ENABLE, 32'(shadow_cfg.enable));
        wb_check(ADR_MODE, 32'(shadow_cfg.mode));
        wb_check(ADR_THRESHOLD, 32'(shadow_cfg.threshold));
    endtask

    // Edge beats are gray levels around the threshold, whose luma is the level itself.
    task automatic send_frame(input bit gaps, input bit edges);
        logic [23:0] bits;
        filter_cfg_t frame_cfg;
        pixel_beat_t beat;
        for (int i = 0; i < FRAME_BEATS; i++) begin
            take_bits(stim_lfsr, 24, bits);
            beat.pixel = bits;
            if (edges && i < 3) begin
                beat.pixel = {3{shadow_cfg.threshold + 8'(i) - 8'd1}};
            end
            beat.sof = (i == 0);
            beat.eol = ((i + 1) % LINE_BEATS == 0);
            if (gaps) begin
                take_bits(stim_lfsr, 2, bits);
                while (bits[1:0] == 2'b11) begin
                    @(negedge clk);
                    s_tvalid = 1'b0;
                    take_bits(stim_lfsr, 2, bits);
                end
            end
            @(negedge clk);
            s_tvalid = 1'b1;
            s_tdata  = beat.pixel;
            s_tuser  = beat.sof;
            s_tlast  = beat.eol;
            // Ready only changes on the rising edge.
            while (!s_tready) begin
                @(negedge clk);
            end
            @(posedge clk);
            if (beat.sof) begin
                frame_cfg = shadow_cfg;
            end
            beat.pixel = expected_pixel(beat.pixel, frame_cfg);
            exp_q.push_back(beat);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
        frames_sent++;
    endtask

    // ****************************************
    // Output side.
    // ****************************************

    // A beat seen valid and ready here moves on the next rising edge.
    always @(negedge clk) begin
        if (ready_gaps) begin
            take_bits(ready_lfsr, 2, ready_bits);
            m_tready = (ready_bits[1:0] != 2'b11);
        end else begin
            m_tready = 1'b1;
        end
        if (!rst && m_tvalid && m_tready) begin
            if (exp_q.size() == 0) begin
                $display("An output beat came out with no input beat left to match it.");
                fail_stop();
            end else begin
                exp_out = exp_q.pop_front();
                check_field("m_axi4s_tdata_o", exp_out.pixel, m_tdata);
                check_field("m_axi4s_tuser_o", 24'(exp_out.sof), 24'(m_tuser));
                check_field("m_axi4s_tlast_o", 24'(exp_out.eol), 24'(m_tlast));
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, the run did not end within %0d cycles.", WATCHDOG_CYCLES);
        fail_stop();
    end

    // ****************************************
    // Test sequence.
    // ****************************************

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_we       = 1'b0;
        wb_sel      = '0;
        wb_stb      = 1'b0;
        s_tdata     = '0;
        s_tuser     = 1'b0;
        s_tlast     = 1'b0;
        s_tvalid    = 1'b0;
        m_tready    = 1'b1;
        ready_gaps  = 1'b0;
        stim_lfsr   = LFSR_SEED;
        ready_lfsr  = LFSR_SEED;
        shadow_cfg  = RESET_CFG;
        frames_sent = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        wb_check(ADR_CORE_ID, CORE_ID);
        wb_check(ADR_CORE_VERSION, CORE_VERSION);
        wb_check(ADR_FRAME_COUNT, 32'h0);
        check_cfg_regs();
        // Masked bytes leave the registers alone.
        wb_write(ADR_THRESHOLD, 32'h0000_3300, 4'b0010);
        wb_write(ADR_ENABLE, 32'h0000_0101, 4'b1110);
        wb_write(ADR_MODE, 32'hFFFF_FF03, 4'b1111);
        check_cfg_regs();
        wb_write(ADR_FRAME_COUNT, 32'h1234_5678, 4'b1111);
        wb_check(ADR_FRAME_COUNT, 32'h0);
        wb_check(17'h00005, 32'h0);
        wb_check(17'h1F000, 32'h0);

        // Bypass with a non-pass mode selected.
        wb_write(ADR_MODE, 32'h1, 4'b0001);
        send_frame(1'b0, 1'b0);
        send_frame(1'b0, 1'b0);

        wb_write(ADR_ENABLE, 32'h1, 4'b1111);
        send_frame(1'b0, 1'b0);
        wb_write(ADR_MODE, 32'h2, 4'b1111);
        send_frame(1'b0, 1'b0);
        wb_write(ADR_THRESHOLD, 32'h5A, 4'b0001);
        wb_write(ADR_MODE, 32'h3, 4'b1111);
        check_cfg_regs();
        send_frame(1'b0, 1'b1);

        // Mode written in the middle of a frame.
        wb_write(ADR_MODE, 32'h1, 4'b1111);
        fork
            send_frame(1'b0, 1'b0);
            begin
                repeat (6) @(posedge clk);
                wb_write(ADR_MODE, 32'h2, 4'b1111);
            end
        join
        send_frame(1'b0, 1'b0);

        @(posedge clk);
        ready_gaps = 1'b1;
        wb_write(ADR_MODE, 32'h0, 4'b1111);
        send_frame(1'b1, 1'b0);
        wb_write(ADR_MODE, 32'h1, 4'b1111);
        send_frame(1'b1, 1'b0);
        wb_write(ADR_MODE, 32'h2, 4'b1111);
        send_frame(1'b1, 1'b0);
        wb_write(ADR_MODE, 32'h3, 4'b1111);
        send_frame(1'b1, 1'b1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        wb_check(ADR_FRAME_COUNT, 32'(frames_sent));

        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        shadow_cfg = RESET_CFG;
        wb_check(ADR_FRAME_COUNT, 32'h0);
        check_cfg_regs();

        if (DUT.u_assertions.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times.", DUT.u_assertions.fail_count);
            fail_stop();
        end
    end

endmodule

`default_nettype wire

//--- video_filter.f
hdl/video_filter_pkg.sv
hdl/video_filter_regs.sv
hdl/video_filter_pixel_op.sv
hdl/video_filter_out_buf.sv
hdl/video_filter.sv
sim/video_filter_assertions.sv
sim/tb_video_filter.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP        = tb_video_filter
RTL_TOP    = video_filter
FILELIST   = video_filter.f
OBJ_DIR    = obj_dir
PASS_MSG   = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
